// ==== build.f ====
+incdir+common
common/cache_pkg.sv
cacheTable/lineRam.sv
cacheTable/cacheTable.sv
rtl/memArbiter.sv
rtl/lineCopier.sv
rtl/cacheSubsys.sv
dv/cacheSubsys_sva.sv
dv/cacheSubsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= cacheSubsys_tb
RTL_TOP   ?= cacheSubsys
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Verification passed" $(LOG) || \
		(echo "Simulation of $(RTL_TOP) did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/cacheSubsys_tb.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cacheSubsys_tb;

    localparam int timeoutCycles = 200;

    logic               clk;
    logic               rst;
    logic               instrLookupValid;
    logic [`ADDR_W-1:0] instrLookupAddr;
    logic               instrStall;
    logic               instrDataValid;
    logic [`DATA_W-1:0] instrData;
    logic               dataLookupValid;
    logic [`ADDR_W-1:0] dataLookupAddr;
    logic               dataStall;
    logic               dataDataValid;
    logic [`DATA_W-1:0] dataData;
    logic               extReq;
    logic [`ADDR_W-1:0] extAddr;
    logic [`DATA_W-1:0] extData;

    logic               memPending;
    logic [`ADDR_W-1:0] memAddr;

    int     errorCount;
    int     testsRun;
    int     testsFailed;
    int     testStartErrors;
    bit     timedOut;
    integer seed;

    cacheSubsys dut0 (
        .clk(clk), .rst(rst),
        .instrLookupValid(instrLookupValid), .instrLookupAddr(instrLookupAddr),
        .instrStall(instrStall), .instrDataValid(instrDataValid), .instrData(instrData),
        .dataLookupValid(dataLookupValid), .dataLookupAddr(dataLookupAddr),
        .dataStall(dataStall), .dataDataValid(dataDataValid), .dataData(dataData),
        .extReq(extReq), .extAddr(extAddr), .extData(extData)
    );

    always #2 clk = ~clk;

    // External memory, data lands on the cycle after extReq
    always @(negedge clk) begin
        extData = memPending ? expectedWord(memAddr) : '0;
        memPending = extReq;
        memAddr = extAddr;
    end

    function automatic logic [`DATA_W-1:0] expectedWord(input logic [`ADDR_W-1:0] addr);
        logic [`DATA_W-1:0] wide;
        wide = `DATA_W'(addr);
        return (wide * `DATA_W'(3)) ^ `DATA_W'(32'h5A5A_A5A5);
    endfunction

    function automatic logic stallOf(input cache_pkg::clientId_t port);
        return (port == cache_pkg::CLIENT_INSTR) ? instrStall : dataStall;
    endfunction

    function automatic logic validOf(input cache_pkg::clientId_t port);
        return (port == cache_pkg::CLIENT_INSTR) ? instrDataValid : dataDataValid;
    endfunction

    function automatic logic [`DATA_W-1:0] wordOf(input cache_pkg::clientId_t port);
        return (port == cache_pkg::CLIENT_INSTR) ? instrData : dataData;
    endfunction

    task automatic driveLookup(input cache_pkg::clientId_t port, input logic valid,
                               input logic [`ADDR_W-1:0] addr);
        if (port == cache_pkg::CLIENT_INSTR) begin
            instrLookupValid = valid;
            instrLookupAddr = addr;
        end else begin
            dataLookupValid = valid;
            dataLookupAddr = addr;
        end
    endtask

    task automatic checkWord(input cache_pkg::clientId_t port, input logic [`ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] got);
        logic [`DATA_W-1:0] exp;
        exp = expectedWord(addr);
        if (got !== exp) begin
            $display("Error at %0t: %s word at %h is %h, expected %h",
                     $time, port.name(), addr, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkStall(input cache_pkg::clientId_t port, input logic exp);
        if (stallOf(port) !== exp) begin
            $display("Error at %0t: %s stall is %b, expected %b",
                     $time, port.name(), stallOf(port), exp);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // One lookup: wait out the stall, then expect data on the next cycle
    task automatic lookup(input cache_pkg::clientId_t port, input logic [`ADDR_W-1:0] addr,
                          input int expStall);
        int n;
        @(negedge clk);
        driveLookup(port, 1'b1, addr);
        #1;
        if (expStall >= 0)
            checkStall(port, expStall[0]);
        n = 0;
        while (stallOf(port) && n < timeoutCycles) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (stallOf(port)) begin
            $display("Timeout: %s stall stayed high for %0d cycles at address %h",
                     port.name(), timeoutCycles, addr);
            errorCount++;
            timedOut = 1'b1;
            driveLookup(port, 1'b0, addr);
        end else begin
            @(negedge clk);
            driveLookup(port, 1'b0, addr);
            n = 0;
            while (!validOf(port) && n < timeoutCycles) begin
                @(negedge clk);
                n++;
            end
            if (!validOf(port)) begin
                $display("Timeout: %s dataValid never rose for address %h", port.name(), addr);
                errorCount++;
                timedOut = 1'b1;
            end else begin
                if (n != 0) begin
                    $display("Error at %0t: %s data came %0d cycles late", $time, port.name(), n);
                    errorCount++;
                end
                checkWord(port, addr, wordOf(port));
            end
        end
    endtask

    task automatic resetOutputs();
        @(negedge clk);
        #1;
        checkStall(cache_pkg::CLIENT_INSTR, 1'b0);
        checkStall(cache_pkg::CLIENT_DATA, 1'b0);
        checkFlag("instrDataValid", instrDataValid, 1'b0);
        checkFlag("dataDataValid", dataDataValid, 1'b0);
        checkFlag("extReq", extReq, 1'b0);
    endtask

    task automatic coldMissThenHit();
        lookup(cache_pkg::CLIENT_INSTR, 16'h0123, 1);
        lookup(cache_pkg::CLIENT_INSTR, 16'h0125, 0);
    endtask

    task automatic dualMiss();
        fork
            lookup(cache_pkg::CLIENT_INSTR, 16'h0240, 1);
            lookup(cache_pkg::CLIENT_DATA, 16'h0388, 1);
        join
    endtask

    // One more line than the table holds
    task automatic evictAndReload();
        for (int i = 0; i <= `NUM_LINES; i++)
            lookup(cache_pkg::CLIENT_DATA, `ADDR_W'(32'h0800 + i * `LINE_WORDS + i), -1);
        for (int i = 0; i <= `NUM_LINES; i++)
            lookup(cache_pkg::CLIENT_DATA,
                   `ADDR_W'(32'h0800 + i * `LINE_WORDS + `LINE_WORDS - 1), -1);
    endtask

    task automatic randomMix();
        logic [`ADDR_W-1:0] instrAddr;
        logic [`ADDR_W-1:0] dataAddr;
        for (int i = 0; i < 100; i++) begin
            instrAddr = `ADDR_W'($random(seed) & 63);
            dataAddr = `ADDR_W'($random(seed) & 63);
            fork
                lookup(cache_pkg::CLIENT_INSTR, instrAddr, -1);
                lookup(cache_pkg::CLIENT_DATA, dataAddr, -1);
            join
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount != testStartErrors) begin
            testsFailed++;
            $display("Test %0d %s: FAILED", testsRun, name);
        end else begin
            $display("Test %0d %s: ok", testsRun, name);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instrLookupValid = 1'b0;
        instrLookupAddr = '0;
        dataLookupValid = 1'b0;
        dataLookupAddr = '0;
        extData = '0;
        memPending = 1'b0;
        memAddr = '0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        testStartErrors = 0;
        timedOut = 1'b0;
        seed = 32'hc0e3;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        resetOutputs();
        finishTest("reset outputs");
        if (!timedOut) begin
            coldMissThenHit();
            finishTest("instr cold miss then hit");
        end
        if (!timedOut) begin
            dualMiss();
            finishTest("simultaneous misses");
        end
        if (!timedOut) begin
            evictAndReload();
            finishTest("data eviction and reload");
        end
        if (!timedOut) begin
            randomMix();
            finishTest("random addresses");
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== dv/cacheSubsys_sva.sv ====
`timescale 1ns/1ps

module cacheSubsys_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input logic                 grantHeld,
    input cache_pkg::clientId_t client,
    input logic                 extReq
);

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    // Four-phase, req held until acked
    reqHeld: assert property (@(posedge clk) disable iff (rst) req && !ack |=> req)
        else $error("req dropped before its ack");

    clientStable: assert property (@(posedge clk) disable iff (rst)
        $past(grantHeld) && grantHeld |-> $stable(client))
        else $error("copyClient changed during an open copy request");

    // Memory reads only while a copy request is open
    extOnlyInCopy: assert property (@(posedge clk) disable iff (rst) extReq |-> req)
        else $error("extReq without an open copy request");

endmodule

bind memArbiter cacheSubsys_sva instrSva (
    .clk(clk), .rst(rst), .req(instrReq), .ack(instrAck),
    .grantHeld(copyReq), .client(copyClient), .extReq(1'b0)
);

bind memArbiter cacheSubsys_sva dataSva (
    .clk(clk), .rst(rst), .req(dataReq), .ack(dataAck),
    .grantHeld(copyReq), .client(copyClient), .extReq(1'b0)
);

bind lineCopier cacheSubsys_sva copySva (
    .clk(clk), .rst(rst), .req(copyReq), .ack(copyAck),
    .grantHeld(copyReq), .client(copyClient), .extReq(extReq)
);

// ==== rtl/cacheSubsys.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cacheSubsys (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrLookupValid,
    input  logic [`ADDR_W-1:0]   instrLookupAddr,
    output logic                 instrStall,
    output logic                 instrDataValid,
    output logic [`DATA_W-1:0]   instrData,
    input  logic                 dataLookupValid,
    input  logic [`ADDR_W-1:0]   dataLookupAddr,
    output logic                 dataStall,
    output logic                 dataDataValid,
    output logic [`DATA_W-1:0]   dataData,
    output logic                 extReq,
    output logic [`ADDR_W-1:0]   extAddr,
    input  logic [`DATA_W-1:0]   extData
);

    logic [`SLOT_W+`OFFSET_W-1:0] instrRamAddr;
    logic [`SLOT_W+`OFFSET_W-1:0] dataRamAddr;
    logic [`SLOT_W+`OFFSET_W-1:0] wrAddr;
    logic [`DATA_W-1:0]           wrData;
    logic                         instrRdEn;
    logic                         dataRdEn;
    logic                         instrWrEn;
    logic                         dataWrEn;

    logic                 instrFillReq;
    logic                 instrFillAck;
    logic [`TAG_W-1:0]    instrFillTag;
    logic [`SLOT_W-1:0]   instrFillSlot;
    logic                 dataFillReq;
    logic                 dataFillAck;
    logic [`TAG_W-1:0]    dataFillTag;
    logic [`SLOT_W-1:0]   dataFillSlot;

    logic                 copyReq;
    logic                 copyAck;
    logic [`TAG_W-1:0]    copyTag;
    logic [`SLOT_W-1:0]   copySlot;
    cache_pkg::clientId_t copyClient;

    // Accepted lookups read the line RAM
    assign instrRdEn = instrLookupValid && !instrStall;
    assign dataRdEn  = dataLookupValid && !dataStall;

    cacheTable instrTable (
        .clk(clk), .rst(rst),
        .lookupValid(instrLookupValid), .lookupAddr(instrLookupAddr),
        .stall(instrStall), .ramAddr(instrRamAddr),
        .fillReq(instrFillReq), .fillTag(instrFillTag),
        .fillSlot(instrFillSlot), .fillAck(instrFillAck)
    );

    lineRam instrRam (
        .clk(clk), .rdEn(instrRdEn), .rdAddr(instrRamAddr),
        .rdData(instrData), .rdValid(instrDataValid),
        .wrEn(instrWrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    cacheTable dataTable (
        .clk(clk), .rst(rst),
        .lookupValid(dataLookupValid), .lookupAddr(dataLookupAddr),
        .stall(dataStall), .ramAddr(dataRamAddr),
        .fillReq(dataFillReq), .fillTag(dataFillTag),
        .fillSlot(dataFillSlot), .fillAck(dataFillAck)
    );

    lineRam dataRam (
        .clk(clk), .rdEn(dataRdEn), .rdAddr(dataRamAddr),
        .rdData(dataData), .rdValid(dataDataValid),
        .wrEn(dataWrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    memArbiter arb0 (
        .clk(clk), .rst(rst),
        .instrReq(instrFillReq), .instrTag(instrFillTag),
        .instrSlot(instrFillSlot), .instrAck(instrFillAck),
        .dataReq(dataFillReq), .dataTag(dataFillTag),
        .dataSlot(dataFillSlot), .dataAck(dataFillAck),
        .copyReq(copyReq), .copyTag(copyTag), .copySlot(copySlot),
        .copyClient(copyClient), .copyAck(copyAck)
    );

    lineCopier copier0 (
        .clk(clk), .rst(rst),
        .copyReq(copyReq), .copyTag(copyTag), .copySlot(copySlot),
        .copyClient(copyClient), .copyAck(copyAck),
        .extReq(extReq), .extAddr(extAddr), .extData(extData),
        .instrWrEn(instrWrEn), .dataWrEn(dataWrEn),
        .wrAddr(wrAddr), .wrData(wrData)
    );

endmodule

// ==== rtl/lineCopier.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module lineCopier (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          copyReq,
    input  logic [`TAG_W-1:0]             copyTag,
    input  logic [`SLOT_W-1:0]            copySlot,
    input  cache_pkg::clientId_t          copyClient,
    output logic                          copyAck,
    output logic                          extReq,
    output logic [`ADDR_W-1:0]            extAddr,
    input  logic [`DATA_W-1:0]            extData,
    output logic                          instrWrEn,
    output logic                          dataWrEn,
    output logic [`SLOT_W+`OFFSET_W-1:0]  wrAddr,
    output logic [`DATA_W-1:0]            wrData
);

    localparam logic [`OFFSET_W-1:0] lastWord = `OFFSET_W'(`LINE_WORDS - 1);

    cache_pkg::copyState_t state;

    logic [`OFFSET_W-1:0] wordIdx;
    logic [`OFFSET_W-1:0] wrOffset;
    logic                 wrPending;

    assign extReq  = (state == cache_pkg::CS_READ);
    assign extAddr = {copyTag, wordIdx};
    assign copyAck = (state == cache_pkg::CS_ACK);

    // Memory answers one cycle after the request
    assign wrAddr    = {copySlot, wrOffset};
    assign wrData    = extData;
    assign instrWrEn = wrPending && (copyClient == cache_pkg::CLIENT_INSTR);
    assign dataWrEn  = wrPending && (copyClient == cache_pkg::CLIENT_DATA);

    always_ff @(posedge clk) begin
        wrOffset <= wordIdx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::CS_IDLE;
            wordIdx <= '0;
            wrPending <= 1'b0;
        end else begin
            wrPending <= extReq;
            case (state)
                cache_pkg::CS_IDLE: begin
                    wordIdx <= '0;
                    if (copyReq)
                        state <= cache_pkg::CS_READ;
                end

                cache_pkg::CS_READ: begin
                    wordIdx <= wordIdx + 1'b1;
                    if (wordIdx == lastWord)
                        state <= cache_pkg::CS_ACK;
                end

                cache_pkg::CS_ACK: begin
                    // Last word lands on the first ack cycle
                    if (!copyReq)
                        state <= cache_pkg::CS_IDLE;
                end

                default: state <= cache_pkg::CS_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/memArbiter.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module memArbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrReq,
    input  logic [`TAG_W-1:0]     instrTag,
    input  logic [`SLOT_W-1:0]    instrSlot,
    output logic                  instrAck,
    input  logic                  dataReq,
    input  logic [`TAG_W-1:0]     dataTag,
    input  logic [`SLOT_W-1:0]    dataSlot,
    output logic                  dataAck,
    output logic                  copyReq,
    output logic [`TAG_W-1:0]     copyTag,
    output logic [`SLOT_W-1:0]    copySlot,
    output cache_pkg::clientId_t  copyClient,
    input  logic                  copyAck
);

    logic                 busy;
    logic                 grantInstr;
    cache_pkg::clientId_t grant;
    cache_pkg::clientId_t lastServed;
    cache_pkg::clientId_t nextClient;

    // Tie goes to whoever was not served last
    always_comb begin
        if (instrReq && dataReq)
            nextClient = (lastServed == cache_pkg::CLIENT_INSTR) ?
                         cache_pkg::CLIENT_DATA : cache_pkg::CLIENT_INSTR;
        else if (instrReq)
            nextClient = cache_pkg::CLIENT_INSTR;
        else
            nextClient = cache_pkg::CLIENT_DATA;
    end

    assign grantInstr = (grant == cache_pkg::CLIENT_INSTR);
    assign copyClient = grant;
    assign copyReq    = busy && (grantInstr ? instrReq : dataReq);
    assign copyTag    = grantInstr ? instrTag : dataTag;
    assign copySlot   = grantInstr ? instrSlot : dataSlot;
    assign instrAck   = busy && grantInstr && copyAck;
    assign dataAck    = busy && !grantInstr && copyAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            grant <= cache_pkg::CLIENT_INSTR;
            lastServed <= cache_pkg::CLIENT_DATA;
        end else if (!busy) begin
            if (instrReq || dataReq) begin
                busy <= 1'b1;
                grant <= nextClient;
            end
        end else if (!copyReq && !copyAck) begin
            // Both halves of the handshake are back low
            busy <= 1'b0;
            lastServed <= grant;
        end
    end

endmodule

// ==== cacheTable/cacheTable.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cacheTable #(
    parameter int numLines = `NUM_LINES
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   lookupValid,
    input  logic [`ADDR_W-1:0]                     lookupAddr,
    output logic                                   stall,
    output logic [$clog2(numLines)+`OFFSET_W-1:0]  ramAddr,
    output logic                                   fillReq,
    output logic [`TAG_W-1:0]                      fillTag,
    output logic [$clog2(numLines)-1:0]            fillSlot,
    input  logic                                   fillAck
);

    localparam int slotW = $clog2(numLines);

    cache_pkg::tableState_t state;

    logic [`TAG_W-1:0]    tags [numLines];
    logic [numLines-1:0]  valid;
    logic [numLines-1:0]  used;
    logic [slotW-1:0]     victimPtr;

    logic [`TAG_W-1:0]    lookupTag;
    logic [`OFFSET_W-1:0] lookupOffset;
    logic                 hit;
    logic [slotW-1:0]     hitSlot;
    logic                 accepted;

    assign lookupTag    = lookupAddr[`ADDR_W-1:`OFFSET_W];
    assign lookupOffset = lookupAddr[`OFFSET_W-1:0];

    // Fully associative compare over all valid entries
    always_comb begin
        hit = 1'b0;
        hitSlot = '0;
        for (int i = 0; i < numLines; i++) begin
            if (valid[i] && tags[i] == lookupTag) begin
                hit = 1'b1;
                hitSlot = slotW'(i);
            end
        end
    end

    assign stall    = (lookupValid && !hit) || (state != cache_pkg::TS_IDLE);
    assign accepted = lookupValid && !stall;
    assign ramAddr  = {hitSlot, lookupOffset};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::TS_IDLE;
            valid <= '0;
            used <= '0;
            victimPtr <= '0;
            fillReq <= 1'b0;
        end else begin
            case (state)
                cache_pkg::TS_IDLE: begin
                    if (lookupValid && !hit) begin
                        // Victim is dropped now so a stale hit cannot happen mid-fill
                        valid[victimPtr] <= 1'b0;
                        fillTag <= lookupTag;
                        fillSlot <= victimPtr;
                        fillReq <= 1'b1;
                        state <= cache_pkg::TS_REQ;
                    end else if (valid[victimPtr] && used[victimPtr]) begin
                        // Second chance, clear and move on
                        used[victimPtr] <= 1'b0;
                        victimPtr <= victimPtr + 1'b1;
                    end
                end

                cache_pkg::TS_REQ: begin
                    if (fillAck) begin
                        tags[fillSlot] <= fillTag;
                        valid[fillSlot] <= 1'b1;
                        used[fillSlot] <= 1'b1;
                        victimPtr <= fillSlot + 1'b1;
                        fillReq <= 1'b0;
                        state <= cache_pkg::TS_RELEASE;
                    end
                end

                cache_pkg::TS_RELEASE: begin
                    if (!fillAck)
                        state <= cache_pkg::TS_IDLE;
                end

                default: state <= cache_pkg::TS_IDLE;
            endcase

            // Placed last so a fresh hit outranks the pointer sweep
            if (accepted)
                used[hitSlot] <= 1'b1;
        end
    end

endmodule

// ==== cacheTable/lineRam.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module lineRam (
    input  logic                           clk,
    input  logic                           rdEn,
    input  logic [`SLOT_W+`OFFSET_W-1:0]   rdAddr,
    output logic [`DATA_W-1:0]             rdData,
    output logic                           rdValid,
    input  logic                           wrEn,
    input  logic [`SLOT_W+`OFFSET_W-1:0]   wrAddr,
    input  logic [`DATA_W-1:0]             wrData
);

    logic [`DATA_W-1:0] mem [`NUM_LINES*`LINE_WORDS];

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrAddr] <= wrData;
        if (rdEn)
            rdData <= mem[rdAddr];
        // One cycle after an accepted lookup
        rdValid <= rdEn;
    end

endmodule

// ==== common/cache_pkg.sv ====
package cache_pkg;

    // Fill control in each tag table
    typedef enum logic [1:0] {
        TS_IDLE    = 2'd0,
        TS_REQ     = 2'd1,
        TS_RELEASE = 2'd2
    } tableState_t;

    // Line copier sequencing
    typedef enum logic [1:0] {
        CS_IDLE = 2'd0,
        CS_READ = 2'd1,
        CS_ACK  = 2'd2
    } copyState_t;

    // Requesters on the fill path
    typedef enum logic {
        CLIENT_INSTR = 1'b0,
        CLIENT_DATA  = 1'b1
    } clientId_t;

endpackage

// ==== common/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Word address and data widths
`define ADDR_W 16
`define DATA_W 32

// Line geometry
`define LINE_WORDS 8
`define NUM_LINES 4

// Derived widths, tag is what is left above the offset
`define OFFSET_W ($clog2(`LINE_WORDS))
`define TAG_W (`ADDR_W - `OFFSET_W)
`define SLOT_W ($clog2(`NUM_LINES))

`endif
